// File: Bender.yml
package:
  name: dtpu

sources:
  - include_dirs:
      - source
    files:
      - source/dtpu_pkg.sv
      - source/ls_ctrl_if.sv
      - source/mxu_array.sv
      - source/control_unit.sv
      - source/ls_array.sv
      - source/dtpu_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/dtpu_tb_models.sv
      - tests/dtpu_core_tb.sv

// File: dtpu.f
+incdir+source
source/dtpu_pkg.sv
source/ls_ctrl_if.sv
source/mxu_array.sv
source/control_unit.sv
source/ls_array.sv
source/dtpu_core.sv
tests/dtpu_tb_models.sv
tests/dtpu_core_tb.sv

// File: source/control_unit.sv
`timescale 1ns/1ps
`include "dtpu_consts.svh"

module control_unit (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic                          enable_i,
  input  logic                          cs_start_i,
  input  logic                          cs_continue_i,
  output logic                          cs_ready_o,
  output logic                          cs_done_o,
  output logic                          cs_idle_o,
  output logic [3:0]                    state_o,
  output logic                          csr_ce_o,
  output logic [`DTPU_CSR_ADDR_W-1:0]   csr_address_o,
  input  logic [`DTPU_CSR_W-1:0]        csr_dout_i,
  output logic                          wm_ce_o,
  output logic [`DTPU_WM_ADDR_W-1:0]    wm_address_o,
  ls_ctrl_if.ctrl                       ls
);

  localparam int ROWS   = `DTPU_ROWS;
  localparam int ROW_W  = $clog2(ROWS);
  localparam int FCNT_W = $clog2(ROWS + 1);
  localparam int WM_AW  = `DTPU_WM_ADDR_W;
  localparam int CSR_AW = `DTPU_CSR_ADDR_W;

  typedef enum logic [3:0] {
    IDLE      = 4'd0,
    READ_CFG0 = 4'd1,
    READ_CFG1 = 4'd2,
    FETCH_W   = 4'd3,
    STREAM    = 4'd4,
    DONE      = 4'd5
  } state_e;

  state_e                   state_q, state_d;
  logic [FCNT_W-1:0]        fcnt_q;     // weight fetch step, 0..ROWS
  dtpu_pkg::precision_e     prec_q;
  logic [`DTPU_VCNT_W-1:0]  n_q;
  logic [`DTPU_CSR_W-1:0]   page_q;
  logic [`DTPU_CSR_W-1:0]   page_sel;
  logic                     fetch_last;

  ////////////////////////////////////////////////////////////
  // job FSM
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (cs_start_i) state_d = READ_CFG0;
      READ_CFG0: state_d = READ_CFG1;
      READ_CFG1: state_d = FETCH_W;
      FETCH_W:   if (fetch_last) state_d = STREAM;
      STREAM:    if (ls.stream_done) state_d = DONE;
      DONE:      if (cs_continue_i) state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= IDLE;
      fcnt_q  <= '0;
      prec_q  <= dtpu_pkg::PREC_INT8;
      n_q     <= '0;
      page_q  <= '0;
    end else if (enable_i) begin
      state_q <= state_d;
      // byte 0 is on the bus while byte 1 is addressed
      if (state_q == READ_CFG1) begin
        prec_q <= dtpu_pkg::precision_e'(csr_dout_i[0]);
        n_q    <= csr_dout_i[`DTPU_CSR_W-1:1];
      end
      if (state_q == FETCH_W) begin
        fcnt_q <= fetch_last ? '0 : fcnt_q + 1'b1;
        if (fcnt_q == '0) page_q <= csr_dout_i;  // byte 1 arrives here
      end
    end
  end

  assign fetch_last = (fcnt_q == FCNT_W'(ROWS));

  // first fetch cycle takes the page straight from the CSR bus
  assign page_sel = (fcnt_q == '0) ? csr_dout_i : page_q;

  ////////////////////////////////////////////////////////////
  // memory ports and handshake
  ////////////////////////////////////////////////////////////
  assign csr_ce_o      = enable_i & ((state_q == READ_CFG0) | (state_q == READ_CFG1));
  assign csr_address_o = CSR_AW'(state_q == READ_CFG1);

  assign wm_ce_o      = enable_i & (state_q == FETCH_W) & ~fetch_last;
  assign wm_address_o = WM_AW'(page_sel) * WM_AW'(ROWS) + WM_AW'(fcnt_q);

  assign cs_idle_o  = (state_q == IDLE);
  assign cs_ready_o = cs_idle_o & cs_start_i & enable_i;  // same cycle as accept
  assign cs_done_o  = (state_q == DONE);
  assign state_o    = state_q;

  // data for row k shows up one step after its address
  assign ls.weight_we    = enable_i & (state_q == FETCH_W) & (fcnt_q != '0);
  assign ls.weight_row   = ROW_W'(fcnt_q - 1'b1);
  assign ls.stream_start = enable_i & (state_q == FETCH_W) & fetch_last;
  assign ls.precision    = prec_q;
  assign ls.vec_count    = n_q;

endmodule

// File: source/dtpu_consts.svh
`ifndef DTPU_CONSTS_SVH
`define DTPU_CONSTS_SVH

// array geometry
`define DTPU_ROWS        4  // weight rows, one output lane each
`define DTPU_COLUMNS     4  // active input lanes per vector

// data path and memory buses
`define DTPU_WORD_W      64
`define DTPU_WM_ADDR_W   16
`define DTPU_CSR_ADDR_W  10
`define DTPU_CSR_W       8

// vector count field of descriptor byte 0
`define DTPU_VCNT_W      7

`endif

// File: source/dtpu_core.sv
`timescale 1ns/1ps
`include "dtpu_consts.svh"

module dtpu_core (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic                          enable_i,

  // ap_ctrl style handshake
  input  logic                          cs_start_i,
  output logic                          cs_ready_o,
  output logic                          cs_done_o,
  input  logic                          cs_continue_i,
  output logic                          cs_idle_o,
  output logic [3:0]                    state_o,

  // CSR block RAM, read only
  output logic                          csr_ce_o,
  output logic [`DTPU_CSR_ADDR_W-1:0]   csr_address_o,
  input  logic [`DTPU_CSR_W-1:0]        csr_dout_i,

  // weight block RAM, read only
  output logic                          wm_ce_o,
  output logic [`DTPU_WM_ADDR_W-1:0]    wm_address_o,
  input  logic [`DTPU_WORD_W-1:0]       wm_dout_i,

  // input FIFO, first word fall-through
  input  logic [`DTPU_WORD_W-1:0]       infifo_dout_i,
  input  logic                          infifo_is_empty_i,
  output logic                          infifo_read_o,

  // output FIFO
  output logic [`DTPU_WORD_W-1:0]       outfifo_din_o,
  input  logic                          outfifo_is_full_i,
  output logic                          outfifo_write_o
);

  ls_ctrl_if ls_bus ();

  ////////////////////////////////////////////////////////////
  // control unit
  ////////////////////////////////////////////////////////////
  control_unit i_control_unit (
    .clk           (clk),
    .reset_i       (reset_i),
    .enable_i      (enable_i),
    .cs_start_i    (cs_start_i),
    .cs_continue_i (cs_continue_i),
    .cs_ready_o    (cs_ready_o),
    .cs_done_o     (cs_done_o),
    .cs_idle_o     (cs_idle_o),
    .state_o       (state_o),
    .csr_ce_o      (csr_ce_o),
    .csr_address_o (csr_address_o),
    .csr_dout_i    (csr_dout_i),
    .wm_ce_o       (wm_ce_o),
    .wm_address_o  (wm_address_o),
    .ls            (ls_bus.ctrl)
  );

  ////////////////////////////////////////////////////////////
  // load/store array with the MAC pipeline
  ////////////////////////////////////////////////////////////
  ls_array i_ls_array (
    .clk               (clk),
    .reset_i           (reset_i),
    .enable_i          (enable_i),
    .ls                (ls_bus.lsu),
    .wm_dout_i         (wm_dout_i),
    .infifo_dout_i     (infifo_dout_i),
    .infifo_is_empty_i (infifo_is_empty_i),
    .infifo_read_o     (infifo_read_o),
    .outfifo_din_o     (outfifo_din_o),
    .outfifo_is_full_i (outfifo_is_full_i),
    .outfifo_write_o   (outfifo_write_o)
  );

endmodule

// File: source/dtpu_pkg.sv
`include "dtpu_consts.svh"

package dtpu_pkg;

  // bit 0 of descriptor byte 0
  typedef enum logic {
    PREC_INT8  = 1'b0,
    PREC_INT16 = 1'b1
  } precision_e;

  typedef logic signed [7:0]  lane8_t;
  typedef logic signed [15:0] lane16_t;

  ////////////////////////////////////////////////////////////
  // one 64 bit word, two lane views
  ////////////////////////////////////////////////////////////
  typedef union packed {
    lane8_t  [`DTPU_WORD_W/8-1:0]  i8;   // 8 x int8
    lane16_t [`DTPU_WORD_W/16-1:0] i16;  // 4 x int16, also result view
  } lane_word_u;

  // one word per weight row
  typedef lane_word_u [`DTPU_ROWS-1:0] weight_mat_t;

endpackage

// File: source/ls_array.sv
`timescale 1ns/1ps
`include "dtpu_consts.svh"

module ls_array (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    enable_i,
  ls_ctrl_if.lsu                  ls,
  input  logic [`DTPU_WORD_W-1:0] wm_dout_i,
  input  logic [`DTPU_WORD_W-1:0] infifo_dout_i,
  input  logic                    infifo_is_empty_i,
  output logic                    infifo_read_o,
  output logic [`DTPU_WORD_W-1:0] outfifo_din_o,
  input  logic                    outfifo_is_full_i,
  output logic                    outfifo_write_o
);

  dtpu_pkg::weight_mat_t    weights_q;
  dtpu_pkg::lane_word_u     act_w;
  dtpu_pkg::lane_word_u     y_w;
  logic [`DTPU_VCNT_W-1:0]  rd_left_q;   // vectors still to read
  logic [`DTPU_VCNT_W-1:0]  wr_left_q;   // results still to write
  logic                     v1_q;        // products stage holds a vector
  logic                     v2_q;        // result stage holds a vector
  logic                     done_pend_q;
  logic                     advance;

  ////////////////////////////////////////////////////////////
  // weight registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (ls.weight_we) weights_q[ls.weight_row] <= wm_dout_i;
  end

  // stalls only when a finished result cannot leave
  assign advance = enable_i & ~(v2_q & outfifo_is_full_i);

  assign infifo_read_o   = advance & (rd_left_q != '0) & ~infifo_is_empty_i;
  assign outfifo_write_o = enable_i & v2_q & ~outfifo_is_full_i;
  assign ls.stream_done  = enable_i & done_pend_q;

  assign act_w         = infifo_dout_i;  // fall-through data, same cycle as read
  assign outfifo_din_o = y_w;

  ////////////////////////////////////////////////////////////
  // counters and pipeline valid bits
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset_i) begin
      rd_left_q   <= '0;
      wr_left_q   <= '0;
      v1_q        <= 1'b0;
      v2_q        <= 1'b0;
      done_pend_q <= 1'b0;
    end else if (enable_i) begin
      done_pend_q <= 1'b0;
      if (ls.stream_start) begin
        rd_left_q   <= ls.vec_count;
        wr_left_q   <= ls.vec_count;
        done_pend_q <= (ls.vec_count == '0);  // empty job
      end else begin
        if (infifo_read_o) rd_left_q <= rd_left_q - 1'b1;
        if (outfifo_write_o) begin
          wr_left_q   <= wr_left_q - 1'b1;
          done_pend_q <= (wr_left_q == `DTPU_VCNT_W'(1));
        end
      end
      if (advance) begin
        v1_q <= infifo_read_o;
        v2_q <= v1_q;
      end
    end
  end

  mxu_array i_mxu_array (
    .clk         (clk),
    .reset_i     (reset_i),
    .advance_i   (advance),
    .precision_i (ls.precision),
    .weights_i   (weights_q),
    .act_i       (act_w),
    .y_o         (y_w)
  );

endmodule

// File: source/ls_ctrl_if.sv
`timescale 1ns/1ps
`include "dtpu_consts.svh"

interface ls_ctrl_if;

  dtpu_pkg::precision_e           precision;
  logic                           weight_we;     // qualifies wm_dout
  logic [$clog2(`DTPU_ROWS)-1:0]  weight_row;
  logic                           stream_start;  // single cycle
  logic [`DTPU_VCNT_W-1:0]        vec_count;
  logic                           stream_done;   // cycle after last write

  modport ctrl (
    output precision, weight_we, weight_row, stream_start, vec_count,
    input  stream_done
  );

  modport lsu (
    input  precision, weight_we, weight_row, stream_start, vec_count,
    output stream_done
  );

endinterface

// File: source/mxu_array.sv
`timescale 1ns/1ps
`include "dtpu_consts.svh"

module mxu_array (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  advance_i,
  input  dtpu_pkg::precision_e  precision_i,
  input  dtpu_pkg::weight_mat_t weights_i,
  input  dtpu_pkg::lane_word_u  act_i,
  output dtpu_pkg::lane_word_u  y_o
);

  localparam int ROWS    = `DTPU_ROWS;
  localparam int COLUMNS = `DTPU_COLUMNS;

  logic signed [31:0]   prod_q [ROWS][COLUMNS];
  logic signed [31:0]   row_sum [ROWS];
  dtpu_pkg::lane_word_u y_d;
  dtpu_pkg::lane_word_u y_q;

  // lane idx of a word, sign extended to 16 bits
  function automatic logic signed [15:0] lane_val(input dtpu_pkg::lane_word_u word,
                                                  input dtpu_pkg::precision_e prec,
                                                  input int idx);
    logic signed [15:0] val;
    if (prec == dtpu_pkg::PREC_INT8) val = {{8{word.i8[idx][7]}}, word.i8[idx]};
    else val = word.i16[idx];
    return val;
  endfunction

  ////////////////////////////////////////////////////////////
  // stage 1, products
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (advance_i) begin
      for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLUMNS; c++) begin
          prod_q[r][c] <= lane_val(weights_i[r], precision_i, c) *
                          lane_val(act_i, precision_i, c);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stage 2, row sums
  ////////////////////////////////////////////////////////////
  always_comb begin
    for (int r = 0; r < ROWS; r++) begin
      row_sum[r] = '0;
      for (int c = 0; c < COLUMNS; c++) row_sum[r] = row_sum[r] + prod_q[r][c];
    end
  end

  always_comb begin
    y_d = '0;
    for (int r = 0; r < ROWS; r++) y_d.i16[r] = row_sum[r][15:0];  // wraps mod 2^16
  end

  always_ff @(posedge clk) begin
    if (reset_i) y_q <= '0;
    else if (advance_i) y_q <= y_d;
  end

  assign y_o = y_q;

endmodule

// File: tests/dtpu_core_tb.sv
`timescale 1ns/1ps
`include "dtpu_consts.svh"

module dtpu_core_tb;

  localparam int ROWS    = `DTPU_ROWS;
  localparam int COLUMNS = `DTPU_COLUMNS;
  localparam int NJOBS   = 6;

  typedef struct {
    string name;
    bit    prec;    // 1 selects int16 lanes
    int    page;
    int    n;
    bit    ostall;  // output FIFO randomly full
    bit    igap;    // input FIFO randomly empty
    int    hold;    // cycles before enable drops or 0 for no hold
  } job_t;

  logic                          clk;
  logic                          reset_i;
  logic                          enable_i;
  logic                          cs_start_i;
  logic                          cs_continue_i;
  logic                          cs_ready_o;
  logic                          cs_done_o;
  logic                          cs_idle_o;
  logic [3:0]                    state_o;
  logic                          csr_ce_o;
  logic [`DTPU_CSR_ADDR_W-1:0]   csr_address_o;
  logic [`DTPU_CSR_W-1:0]        csr_dout_i;
  logic                          wm_ce_o;
  logic [`DTPU_WM_ADDR_W-1:0]    wm_address_o;
  logic [`DTPU_WORD_W-1:0]       wm_dout_i;
  logic [`DTPU_WORD_W-1:0]       infifo_dout_i;
  logic                          infifo_is_empty_i;
  logic                          infifo_read_o;
  logic [`DTPU_WORD_W-1:0]       outfifo_din_o;
  logic                          outfifo_is_full_i;
  logic                          outfifo_write_o;

  job_t        jobs [NJOBS];
  logic [63:0] in_q [$];   // input FIFO contents
  logic [63:0] out_q [$];  // words written by the core
  integer      seed = 32'h7f4e;
  int          rd_cnt;
  int          wr_cnt;
  int          data_errs;
  int          proto_errs;
  int          cur_job;
  int          limit;
  bit          ostall_on;
  bit          igap_on;

  dtpu_core i_dut (.*);

  dtpu_tb_mem #(.ADDR_W(`DTPU_CSR_ADDR_W), .DATA_W(`DTPU_CSR_W), .DEPTH(16)) i_csr_mem (
    .clk(clk), .ce_i(csr_ce_o), .address_i(csr_address_o), .dout_o(csr_dout_i)
  );

  dtpu_tb_mem #(.ADDR_W(`DTPU_WM_ADDR_W), .DATA_W(`DTPU_WORD_W), .DEPTH(64)) i_wm_mem (
    .clk(clk), .ce_i(wm_ce_o), .address_i(wm_address_o), .dout_o(wm_dout_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_protocol(input string what);
    $display("protocol failure in %s: %s", jobs[cur_job].name, what);
    proto_errs++;
  endtask

  // output lane r is the low half of the dot product of row r and x
  function automatic logic [63:0] reference_result(input logic [ROWS-1:0][63:0] w,
                                                   input logic [63:0] x, input bit prec);
    logic [63:0] y;
    int acc;
    int wv;
    int xv;
    y = '0;
    for (int r = 0; r < ROWS; r++) begin
      acc = 0;
      for (int c = 0; c < COLUMNS; c++) begin
        if (prec) begin
          wv = $signed(w[r][16*c +: 16]);
          xv = $signed(x[16*c +: 16]);
        end else begin
          wv = $signed(w[r][8*c +: 8]);
          xv = $signed(x[8*c +: 8]);
        end
        acc = acc + wv * xv;
      end
      y[16*r +: 16] = acc[15:0];
    end
    return y;
  endfunction

  ////////////////////////////////////////////////////////////
  // FIFO models and strobe monitor
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    outfifo_is_full_i = ostall_on && ($random(seed) % 3 == 0);
    infifo_is_empty_i = (in_q.size() == 0) || (igap_on && ($random(seed) % 3 == 0));
    infifo_dout_i     = (in_q.size() != 0) ? in_q[0] : '0;
    #1;  // let the strobes settle before the next rising edge
    if (infifo_read_o) begin
      if (infifo_is_empty_i) begin
        report_protocol("read while the input FIFO is empty");
      end else begin
        void'(in_q.pop_front());
        rd_cnt++;
      end
    end
    if (outfifo_write_o) begin
      if (outfifo_is_full_i) begin
        report_protocol("write while the output FIFO is full");
      end else begin
        out_q.push_back(outfifo_din_o);
        wr_cnt++;
      end
    end
    if (wm_ce_o && (wm_address_o < jobs[cur_job].page * ROWS ||
                    wm_address_o >= jobs[cur_job].page * ROWS + ROWS)) begin
      report_protocol("weight address outside the job's page");
    end
    if (!enable_i &&
        (infifo_read_o || outfifo_write_o || csr_ce_o || wm_ce_o || cs_ready_o)) begin
      report_protocol("strobe active while enable is low");
    end
  end

  task automatic run_job(input int j);
    logic [ROWS-1:0][63:0] w;
    logic [63:0] x;
    logic [63:0] exp_q [$];
    logic [3:0] held_state;
    int base;
    cur_job = j;
    rd_cnt  = 0;
    wr_cnt  = 0;
    base    = jobs[j].page * ROWS;
    i_csr_mem.mem[0] = {7'(jobs[j].n), jobs[j].prec};
    i_csr_mem.mem[1] = 8'(jobs[j].page);
    for (int r = 0; r < ROWS; r++) begin
      w[r] = {$random(seed), $random(seed)};
      w[r][7] = 1'b1;  // negative lane 0 in the int8 view
      i_wm_mem.mem[base + r] = w[r];
    end
    for (int k = 0; k < jobs[j].n; k++) begin
      x = {$random(seed), $random(seed)};
      x[15] = 1'b1;    // negative lane in both views
      in_q.push_back(x);
      exp_q.push_back(reference_result(w, x, jobs[j].prec));
    end
    ostall_on = jobs[j].ostall;
    igap_on   = jobs[j].igap;

    @(negedge clk);
    cs_start_i = 1'b1;
    #1;
    if (!cs_ready_o) report_protocol("no cs_ready_o when start was accepted");
    @(negedge clk);
    cs_start_i = 1'b0;
    @(negedge clk);
    cs_start_i = 1'b1;  // second start while busy
    #1;
    if (cs_ready_o || cs_idle_o) report_protocol("start accepted while a job was running");
    @(negedge clk);
    cs_start_i = 1'b0;
    #1;
    // weight fetch begins three cycles after the accepted start
    if (csr_ce_o || !wm_ce_o) begin
      report_protocol("a start during the job restarted the descriptor read");
    end

    if (jobs[j].hold > 0) begin
      repeat (jobs[j].hold) @(negedge clk);
      enable_i   = 1'b0;
      held_state = state_o;
      repeat (8) begin
        @(negedge clk);
        if (state_o !== held_state) report_protocol("state moved while enable was low");
      end
      enable_i = 1'b1;
    end

    while (!cs_done_o) @(negedge clk);  // job end
    if (wr_cnt != jobs[j].n) report_protocol("cs_done_o rose before the last write");
    repeat (3) begin
      @(negedge clk);
      if (!cs_done_o) report_protocol("cs_done_o fell before cs_continue_i");
    end
    cs_continue_i = 1'b1;
    @(negedge clk);
    cs_continue_i = 1'b0;
    if (!cs_idle_o || cs_done_o) report_protocol("core not idle after cs_continue_i");
    ostall_on = 1'b0;
    igap_on   = 1'b0;

    if (rd_cnt != jobs[j].n || wr_cnt != jobs[j].n) begin
      report_protocol($sformatf("%0d reads and %0d writes for %0d vectors",
                                rd_cnt, wr_cnt, jobs[j].n));
    end
    for (int k = 0; k < exp_q.size() && k < out_q.size(); k++) begin
      if (out_q[k] !== exp_q[k]) begin
        $display("** Error %s: word %0d expected %h, actual %h",
                 jobs[j].name, k, exp_q[k], out_q[k]);
        data_errs++;
      end
    end
    out_q.delete();
    in_q.delete();
  endtask

  ////////////////////////////////////////////////////////////
  // job table and main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    jobs[0] = '{"int8_page0",   1'b0, 0, 6,  1'b0, 1'b0, 0};
    jobs[1] = '{"int16_page2",  1'b1, 2, 5,  1'b0, 1'b0, 0};
    jobs[2] = '{"int8_stalls",  1'b0, 1, 12, 1'b1, 1'b1, 0};
    jobs[3] = '{"int16_stalls", 1'b1, 3, 10, 1'b1, 1'b1, 0};
    jobs[4] = '{"empty_job",    1'b0, 5, 0,  1'b0, 1'b0, 0};
    jobs[5] = '{"enable_hold",  1'b1, 4, 8,  1'b0, 1'b1, 3};
    reset_i           = 1'b1;
    enable_i          = 1'b1;
    cs_start_i        = 1'b0;
    cs_continue_i     = 1'b0;
    infifo_dout_i     = '0;
    infifo_is_empty_i = 1'b1;
    outfifo_is_full_i = 1'b0;
    cur_job           = 0;
    data_errs         = 0;
    proto_errs        = 0;
    limit             = 0;
    for (int j = 0; j < NJOBS; j++) limit += jobs[j].n * 40 + 60;

    repeat (10) @(negedge clk);
    reset_i = 1'b0;
    #1;
    if (!cs_idle_o || cs_done_o || infifo_read_o || outfifo_write_o || csr_ce_o ||
        wm_ce_o || state_o != 4'd0) begin
      $display("outputs not at their reset values after reset");
      proto_errs++;
    end

    for (int j = 0; j < NJOBS; j++) run_job(j);

    $display("errors: %0d data, %0d protocol", data_errs, proto_errs);
    if (data_errs + proto_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // bound on the whole run from the job lengths
  initial begin
    wait (limit > 0);
    repeat (limit + 20) @(posedge clk);
    $display("watchdog expired after %0d cycles, a job never completed", limit + 20);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: tests/dtpu_tb_models.sv
`timescale 1ns/1ps

// block RAM read port, data one cycle after the address
module dtpu_tb_mem #(
  parameter int ADDR_W = 10,
  parameter int DATA_W = 8,
  parameter int DEPTH  = 16
) (
  input  logic              clk,
  input  logic              ce_i,
  input  logic [ADDR_W-1:0] address_i,
  output logic [DATA_W-1:0] dout_o
);

  logic [DATA_W-1:0] mem [DEPTH];

  // background fill, every word differs with its address
  initial begin
    for (int a = 0; a < DEPTH; a++) begin
      mem[a] = DATA_W'({2{a * 32'h9e37_79b1 + 32'h0000_7f4e}});
    end
    dout_o = '0;
  end

  ////////////////////////////////////////////////////////////
  // read port
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (ce_i) begin
      dout_o <= mem[address_i % DEPTH];  // output holds while ce is low
    end
  end

endmodule
